// ==== Bender.yml ====
package:
  name: lsu_slice

sources:
  - files:
      - source/lsu_pkg.sv
      - source/lsu_skid_buffer.sv
      - source/lsu_request_stage.sv
      - source/lsu_load_format.sv
      - source/lsu_commit_arb.sv
      - source/lsu_slice.sv
  - target: test
    files:
      - tests/lsu_slice_assertions.sv
      - tests/lsu_slice_tb.sv

// ==== sim.f ====
source/lsu_pkg.sv
source/lsu_skid_buffer.sv
source/lsu_request_stage.sv
source/lsu_load_format.sv
source/lsu_commit_arb.sv
source/lsu_slice.sv
tests/lsu_slice_assertions.sv
tests/lsu_slice_tb.sv

// ==== source/lsu_commit_arb.sv ====
`default_nettype none
`timescale 1ns/1ps

module lsu_commit_arb (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       load_valid,
    input  lsu_pkg::lsu_commit_t       load,
    output logic                       load_ready,
    input  logic                       store_valid,
    input  lsu_pkg::lsu_store_commit_t store,
    output logic                       store_ready,
    output logic                       commit_valid,
    output lsu_pkg::lsu_commit_t       commit,
    input  logic                       commit_ready
);
    import lsu_pkg::*;

    lsu_commit_t store_wide;
    logic        last_store;
    logic        hold;
    logic        hold_store;
    logic        pick_store;

    // stores carry no write-back data
    assign store_wide.wid   = store.wid;
    assign store_wide.pc    = store.pc;
    assign store_wide.tmask = store.tmask;
    assign store_wide.rd    = '0;
    assign store_wide.wb    = 1'b0;
    assign store_wide.data  = '0;

    // a stalled grant stays put so the commit payload holds
    assign pick_store = hold ? hold_store
                             : (store_valid && (~load_valid || ~last_store));

    assign commit_valid = load_valid || store_valid;
    assign commit       = pick_store ? store_wide : load;
    assign store_ready  = commit_ready && pick_store;
    assign load_ready   = commit_ready && ~pick_store;

    always_ff @(posedge clk) begin
        if (reset) begin
            last_store <= 1'b0;
            hold       <= 1'b0;
            hold_store <= 1'b0;
        end else begin
            hold       <= commit_valid && ~commit_ready;
            hold_store <= pick_store;
            if (commit_valid && commit_ready) begin
                last_store <= pick_store;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/lsu_load_format.sv ====
`default_nettype none
`timescale 1ns/1ps

module lsu_load_format (
    input  logic                  rsp_valid,
    input  lsu_pkg::lsu_mem_rsp_t rsp,
    output logic                  rsp_ready,
    output logic                  out_valid,
    output lsu_pkg::lsu_commit_t  out,
    input  logic                  out_ready
);
    import lsu_pkg::*;

    logic [num_lanes-1:0][15:0]     rsp_half;
    logic [num_lanes-1:0][7:0]      rsp_byte;
    logic [num_lanes-1:0][xlen-1:0] rsp_data;

    assign out_valid = rsp_valid;
    assign rsp_ready = out_ready;

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            // halfword first, then the byte inside it
            rsp_half[i] = rsp.tag.align[i][1] ? rsp.data[i][31:16] : rsp.data[i][15:0];
            rsp_byte[i] = rsp.tag.align[i][0] ? rsp_half[i][15:8] : rsp_half[i][7:0];
            case (rsp.tag.op[2:0])
                fmt_b:   rsp_data[i] = {{(xlen - 8){rsp_byte[i][7]}}, rsp_byte[i]};
                fmt_h:   rsp_data[i] = {{(xlen - 16){rsp_half[i][15]}}, rsp_half[i]};
                fmt_bu:  rsp_data[i] = {{(xlen - 8){1'b0}}, rsp_byte[i]};
                fmt_hu:  rsp_data[i] = {{(xlen - 16){1'b0}}, rsp_half[i]};
                fmt_w:   rsp_data[i] = rsp.data[i];
                default: rsp_data[i] = rsp.data[i];
            endcase
        end
    end

    assign out.wid   = rsp.tag.wid;
    assign out.pc    = rsp.tag.pc;
    assign out.tmask = rsp.mask;
    assign out.rd    = rsp.tag.rd;
    assign out.wb    = 1'b1;
    assign out.data  = rsp_data;

endmodule

`default_nettype wire

// ==== source/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

    localparam int num_lanes      = 4;
    localparam int xlen           = 32;
    localparam int word_bytes     = xlen / 8;
    localparam int align_bits     = 2;
    localparam int word_addr_bits = xlen - align_bits;
    localparam int warp_bits      = 2;
    localparam int reg_bits       = 5;
    localparam int offset_bits    = 12;
    localparam int op_bits        = 4;
    localparam int pc_bits        = 32;

    // op[3] is the store flag, op[2:0] the format
    localparam logic [2:0] fmt_b  = 3'd0;
    localparam logic [2:0] fmt_h  = 3'd1;
    localparam logic [2:0] fmt_w  = 3'd2;
    localparam logic [2:0] fmt_bu = 3'd4;
    localparam logic [2:0] fmt_hu = 3'd5;

    typedef struct packed {
        logic [warp_bits-1:0]                 wid;
        logic [pc_bits-1:0]                   pc;
        logic [num_lanes-1:0]                 tmask;
        logic [reg_bits-1:0]                  rd;
        logic [op_bits-1:0]                   op;
        logic [offset_bits-1:0]               offset;
        logic [num_lanes-1:0][xlen-1:0]       rs1_data;
        logic [num_lanes-1:0][xlen-1:0]       rs2_data;
    } lsu_exec_t;

    // carried through memory and returned with the response
    typedef struct packed {
        logic [warp_bits-1:0]                 wid;
        logic [pc_bits-1:0]                   pc;
        logic [reg_bits-1:0]                  rd;
        logic [op_bits-1:0]                   op;
        logic [num_lanes-1:0][align_bits-1:0] align;
    } lsu_tag_t;

    typedef struct packed {
        logic                                     rw;
        logic [num_lanes-1:0]                     mask;
        logic [num_lanes-1:0][word_bytes-1:0]     byteen;
        logic [num_lanes-1:0][word_addr_bits-1:0] addr;
        logic [num_lanes-1:0][xlen-1:0]           data;
        lsu_tag_t                                 tag;
    } lsu_mem_req_t;

    typedef struct packed {
        logic [num_lanes-1:0]                 mask;
        logic [num_lanes-1:0][xlen-1:0]       data;
        lsu_tag_t                             tag;
    } lsu_mem_rsp_t;

    typedef struct packed {
        logic [warp_bits-1:0]                 wid;
        logic [pc_bits-1:0]                   pc;
        logic [num_lanes-1:0]                 tmask;
    } lsu_store_commit_t;

    typedef struct packed {
        logic [warp_bits-1:0]                 wid;
        logic [pc_bits-1:0]                   pc;
        logic [num_lanes-1:0]                 tmask;
        logic [reg_bits-1:0]                  rd;
        logic                                 wb;
        logic [num_lanes-1:0][xlen-1:0]       data;
    } lsu_commit_t;

endpackage

`default_nettype wire

// ==== source/lsu_request_stage.sv ====
`default_nettype none
`timescale 1ns/1ps

module lsu_request_stage (
    input  logic                       exec_valid,
    input  lsu_pkg::lsu_exec_t         exec,
    output logic                       exec_ready,
    output logic                       mem_req_valid,
    output lsu_pkg::lsu_mem_req_t      mem_req,
    input  logic                       mem_req_ready,
    output logic                       store_valid,
    output lsu_pkg::lsu_store_commit_t store,
    input  logic                       store_ready
);
    import lsu_pkg::*;

    logic [xlen-1:0]                      offset_sext;
    logic [num_lanes-1:0][xlen-1:0]       full_addr;
    logic [num_lanes-1:0][align_bits-1:0] req_align;
    logic [num_lanes-1:0][word_bytes-1:0] req_byteen;
    logic [num_lanes-1:0][xlen-1:0]       req_data;
    logic                                 is_store;
    logic [1:0]                           size;
    logic                                 slot_ok;

    assign is_store = exec.op[op_bits-1];
    // low format bits give the access size for both loads and stores
    assign size = exec.op[1:0];

    assign offset_sext = {{(xlen - offset_bits){exec.offset[offset_bits-1]}}, exec.offset};

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            full_addr[i] = exec.rs1_data[i] + offset_sext;
            req_align[i] = full_addr[i][align_bits-1:0];
        end
    end

    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            req_byteen[i] = '0;
            case (size)
                2'd0: begin
                    req_byteen[i][req_align[i]] = 1'b1;
                end
                2'd1: begin
                    req_byteen[i][{req_align[i][1], 1'b0}] = 1'b1;
                    req_byteen[i][{req_align[i][1], 1'b1}] = 1'b1;
                end
                default: begin
                    req_byteen[i] = '1;
                end
            endcase
        end
    end

    // store operand moved into its byte lanes
    always_comb begin
        for (int i = 0; i < num_lanes; i++) begin
            req_data[i] = exec.rs2_data[i] << {req_align[i], 3'b000};
        end
    end

    always_comb begin
        mem_req.rw     = is_store;
        mem_req.mask   = exec.tmask;
        mem_req.byteen = req_byteen;
        mem_req.data   = req_data;
        for (int i = 0; i < num_lanes; i++) begin
            mem_req.addr[i] = full_addr[i][xlen-1:align_bits];
        end
        mem_req.tag.wid   = exec.wid;
        mem_req.tag.pc    = exec.pc;
        mem_req.tag.rd    = exec.rd;
        mem_req.tag.op    = exec.op;
        mem_req.tag.align = req_align;
    end

    assign store.wid   = exec.wid;
    assign store.pc    = exec.pc;
    assign store.tmask = exec.tmask;

    // a store goes out only with a free commit slot
    assign slot_ok = ~is_store || store_ready;

    assign mem_req_valid = exec_valid && slot_ok;
    assign exec_ready    = mem_req_ready && slot_ok;
    assign store_valid   = exec_valid && is_store && exec_ready;

endmodule

`default_nettype wire

// ==== source/lsu_skid_buffer.sv ====
`default_nettype none
`timescale 1ns/1ps

module lsu_skid_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     in_ready,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);
    payload_t   entry [2];
    logic       wr_ptr;
    logic       rd_ptr;
    logic [1:0] count;
    logic [1:0] count_next;
    logic       push;
    logic       pop;

    assign push = in_valid && in_ready;
    assign pop  = out_valid && out_ready;

    assign count_next = count + 2'(push) - 2'(pop);

    // ready is registered so it never depends on out_ready
    always_ff @(posedge clk) begin
        if (reset) begin
            count    <= '0;
            wr_ptr   <= 1'b0;
            rd_ptr   <= 1'b0;
            in_ready <= 1'b0;
        end else begin
            count    <= count_next;
            in_ready <= (count_next != 2'd2);
            if (push) begin
                wr_ptr <= ~wr_ptr;
            end
            if (pop) begin
                rd_ptr <= ~rd_ptr;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            entry[wr_ptr] <= in_data;
        end
    end

    assign out_valid = (count != 2'd0);
    assign out_data  = entry[rd_ptr];

endmodule

`default_nettype wire

// ==== source/lsu_slice.sv ====
`default_nettype none
`timescale 1ns/1ps

module lsu_slice (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  exec_valid,
    input  lsu_pkg::lsu_exec_t    exec,
    output logic                  exec_ready,
    output logic                  mem_req_valid,
    output lsu_pkg::lsu_mem_req_t mem_req,
    input  logic                  mem_req_ready,
    input  logic                  mem_rsp_valid,
    input  lsu_pkg::lsu_mem_rsp_t mem_rsp,
    output logic                  mem_rsp_ready,
    output logic                  commit_valid,
    output lsu_pkg::lsu_commit_t  commit,
    input  logic                  commit_ready
);
    import lsu_pkg::*;

    logic              st_in_valid;
    lsu_store_commit_t st_in;
    logic              st_in_ready;
    logic              st_out_valid;
    lsu_store_commit_t st_out;
    logic              st_out_ready;

    logic              ld_in_valid;
    lsu_commit_t       ld_in;
    logic              ld_in_ready;
    logic              ld_out_valid;
    lsu_commit_t       ld_out;
    logic              ld_out_ready;

    lsu_request_stage req_stage (
        .exec_valid    (exec_valid),
        .exec          (exec),
        .exec_ready    (exec_ready),
        .mem_req_valid (mem_req_valid),
        .mem_req       (mem_req),
        .mem_req_ready (mem_req_ready),
        .store_valid   (st_in_valid),
        .store         (st_in),
        .store_ready   (st_in_ready)
    );

    lsu_skid_buffer #(.payload_t(lsu_store_commit_t)) store_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (st_in_valid),
        .in_data   (st_in),
        .in_ready  (st_in_ready),
        .out_valid (st_out_valid),
        .out_data  (st_out),
        .out_ready (st_out_ready)
    );

    lsu_load_format load_fmt (
        .rsp_valid (mem_rsp_valid),
        .rsp       (mem_rsp),
        .rsp_ready (mem_rsp_ready),
        .out_valid (ld_in_valid),
        .out       (ld_in),
        .out_ready (ld_in_ready)
    );

    lsu_skid_buffer #(.payload_t(lsu_commit_t)) load_buf (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (ld_in_valid),
        .in_data   (ld_in),
        .in_ready  (ld_in_ready),
        .out_valid (ld_out_valid),
        .out_data  (ld_out),
        .out_ready (ld_out_ready)
    );

    lsu_commit_arb commit_arb (
        .clk          (clk),
        .reset        (reset),
        .load_valid   (ld_out_valid),
        .load         (ld_out),
        .load_ready   (ld_out_ready),
        .store_valid  (st_out_valid),
        .store        (st_out),
        .store_ready  (st_out_ready),
        .commit_valid (commit_valid),
        .commit       (commit),
        .commit_ready (commit_ready)
    );

endmodule

`default_nettype wire

// ==== tests/lsu_slice_assertions.sv ====
`default_nettype none
`timescale 1ns/1ps

module lsu_slice_assertions (
    input logic                  clk,
    input logic                  reset,
    input logic                  exec_valid,
    input lsu_pkg::lsu_exec_t    exec,
    input logic                  exec_ready,
    input logic                  mem_req_valid,
    input lsu_pkg::lsu_mem_req_t mem_req,
    input logic                  mem_req_ready,
    input logic                  mem_rsp_valid,
    input lsu_pkg::lsu_mem_rsp_t mem_rsp,
    input logic                  mem_rsp_ready,
    input logic                  commit_valid,
    input lsu_pkg::lsu_commit_t  commit,
    input logic                  commit_ready
);
    import lsu_pkg::*;

    int   fail_count = 0;
    logic misaligned;

    // active lanes only, size from the low op bits
    always_comb begin
        misaligned = 1'b0;
        for (int i = 0; i < num_lanes; i++) begin
            if (mem_req.mask[i] && mem_req.tag.op[1:0] == 2'd1 && mem_req.tag.align[i][0]) begin
                misaligned = 1'b1;
            end
            if (mem_req.mask[i] && mem_req.tag.op[1] && mem_req.tag.align[i] != '0) begin
                misaligned = 1'b1;
            end
        end
    end

    exec_hold: assert property (@(posedge clk) disable iff (reset)
        exec_valid && !exec_ready |=> exec_valid && $stable(exec))
        else begin fail_count++; $error("exec valid or payload changed while stalled"); end

    mem_req_hold: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid && !mem_req_ready |=> mem_req_valid && $stable(mem_req))
        else begin fail_count++; $error("memory request changed while stalled"); end

    mem_rsp_hold: assert property (@(posedge clk) disable iff (reset)
        mem_rsp_valid && !mem_rsp_ready |=> mem_rsp_valid && $stable(mem_rsp))
        else begin fail_count++; $error("memory response changed while stalled"); end

    commit_hold: assert property (@(posedge clk) disable iff (reset)
        commit_valid && !commit_ready |=> commit_valid && $stable(commit))
        else begin fail_count++; $error("commit changed while stalled"); end

    req_aligned: assert property (@(posedge clk) disable iff (reset)
        mem_req_valid |-> !misaligned)
        else begin fail_count++; $error("request lane not aligned to its access size"); end

    // registers settle one edge into reset
    commit_quiet: assert property (@(posedge clk) reset |=> !commit_valid)
        else begin fail_count++; $error("commit valid during reset"); end

endmodule

bind lsu_slice lsu_slice_assertions protocol_checks (
    .clk           (clk),
    .reset         (reset),
    .exec_valid    (exec_valid),
    .exec          (exec),
    .exec_ready    (exec_ready),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .mem_req_ready (mem_req_ready),
    .mem_rsp_valid (mem_rsp_valid),
    .mem_rsp       (mem_rsp),
    .mem_rsp_ready (mem_rsp_ready),
    .commit_valid  (commit_valid),
    .commit        (commit),
    .commit_ready  (commit_ready)
);

`default_nettype wire

// ==== tests/lsu_slice_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

module lsu_slice_tb;
    import lsu_pkg::*;

    localparam int num_instrs  = 200;
    localparam int mem_bytes   = 1024;
    localparam int wait_limit  = 2000;
    localparam int drain_limit = 20000;

    logic         clk;
    logic         reset;
    logic         exec_valid;
    lsu_exec_t    exec;
    logic         exec_ready;
    logic         mem_req_valid;
    lsu_mem_req_t mem_req;
    logic         mem_req_ready;
    logic         mem_rsp_valid;
    lsu_mem_rsp_t mem_rsp;
    logic         mem_rsp_ready;
    logic         commit_valid;
    lsu_commit_t  commit;
    logic         commit_ready;

    logic [7:0]   mem [mem_bytes];
    logic [7:0]   shadow [mem_bytes];
    lsu_mem_rsp_t rsp_q [$];
    int           due_q [$];
    lsu_commit_t  load_q [$];
    lsu_commit_t  store_q [$];

    int errors        = 0;
    int checks        = 0;
    int loads_issued  = 0;
    int stores_issued = 0;
    int loads_done    = 0;
    int stores_done   = 0;
    int mem_cycle     = 0;
    int mem_stall     = 0;
    int commit_stall  = 0;
    bit timed_out     = 1'b0;

    lsu_slice dut0 (.*);

    always #4 clk = ~clk;

    // expected load value, little endian, from the shadow memory
    function automatic logic [31:0] ref_load(input int addr, input logic [2:0] fmt);
        case (fmt)
            fmt_b:   return {{24{shadow[addr][7]}}, shadow[addr]};
            fmt_bu:  return {24'h0, shadow[addr]};
            fmt_h:   return {{16{shadow[addr + 1][7]}}, shadow[addr + 1], shadow[addr]};
            fmt_hu:  return {16'h0, shadow[addr + 1], shadow[addr]};
            default: return {shadow[addr + 3], shadow[addr + 2], shadow[addr + 1], shadow[addr]};
        endcase
    endfunction

    // mostly ready, with occasional long stalls
    function automatic logic next_ready(inout int stall);
        if (stall > 0) begin
            stall--;
            return 1'b0;
        end
        if ($urandom % 40 == 0) begin
            stall = 8 + $urandom % 40;
            return 1'b0;
        end
        return ($urandom % 4) != 0;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("FAILED %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic finish_run();
        errors += dut0.protocol_checks.fail_count;
        $display("checks %0d, errors %0d (assertions %0d), loads %0d/%0d, stores %0d/%0d",
                 checks, errors, dut0.protocol_checks.fail_count,
                 loads_done, loads_issued, stores_done, stores_issued);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    task automatic report_timeout(input string what);
        errors++;
        timed_out = 1'b1;
        $display("timeout: %s", what);
    endtask

    task automatic check_commit(input lsu_commit_t got);
        lsu_commit_t exp;
        logic        known;
        // every commit seen on the port counts, matched or not
        if (got.wb) begin
            loads_done++;
        end else begin
            stores_done++;
        end
        known = got.wb ? (load_q.size() > 0) : (store_q.size() > 0);
        checks++;
        assert (known) else begin
            errors++;
            $display("commit arrived with no matching instruction outstanding");
        end
        if (known) begin
            if (got.wb) begin
                exp = load_q.pop_front();
            end else begin
                exp = store_q.pop_front();
            end
            compare_field("commit.wid", got.wid, exp.wid);
            compare_field("commit.pc", got.pc, exp.pc);
            compare_field("commit.tmask", got.tmask, exp.tmask);
            compare_field("commit.rd", got.rd, exp.rd);
            for (int i = 0; i < num_lanes; i++) begin
                if (!exp.wb || exp.tmask[i]) begin
                    compare_field($sformatf("commit.data[%0d]", i), got.data[i], exp.data[i]);
                end
            end
        end
    endtask

    task automatic accept_request();
        lsu_mem_rsp_t rsp;
        int           base;
        rsp.mask = mem_req.mask;
        rsp.tag  = mem_req.tag;
        rsp.data = '0;
        for (int i = 0; i < num_lanes; i++) begin
            if (mem_req.mask[i]) begin
                checks++;
                assert (mem_req.addr[i] < mem_bytes / word_bytes) else begin
                    errors++;
                    $display("memory request outside the modeled range");
                end
                base = int'(mem_req.addr[i][7:0]) * word_bytes;
                for (int b = 0; b < word_bytes; b++) begin
                    if (mem_req.rw && mem_req.byteen[i][b]) begin
                        mem[base + b] = mem_req.data[i][8*b +: 8];
                    end
                    rsp.data[i][8*b +: 8] = mem[base + b];
                end
            end
        end
        if (!mem_req.rw) begin
            rsp_q.push_back(rsp);
            due_q.push_back(mem_cycle + $urandom % 6);
        end
    endtask

    // in-order memory model
    always @(posedge clk) begin
        mem_cycle++;
        if (!reset && mem_rsp_valid && mem_rsp_ready) begin
            void'(rsp_q.pop_front());
            void'(due_q.pop_front());
        end
        if (!reset && mem_req_valid && mem_req_ready) begin
            accept_request();
        end
        #1;
        mem_req_ready = !reset && next_ready(mem_stall);
        if (rsp_q.size() > 0 && mem_cycle >= due_q[0]) begin
            mem_rsp_valid = 1'b1;
            mem_rsp       = rsp_q[0];
        end else begin
            mem_rsp_valid = 1'b0;
        end
    end

    always @(posedge clk) begin
        if (!reset && commit_valid && commit_ready) begin
            check_commit(commit);
        end
        #1;
        commit_ready = !reset && next_ready(commit_stall);
    end

    task automatic issue_one();
        lsu_exec_t   ins;
        lsu_commit_t exp;
        int          eff [num_lanes];
        logic [31:0] off_sext;
        logic [1:0]  size;
        int          waited;
        case ($urandom % 8)
            0: ins.op = {1'b0, fmt_b};
            1: ins.op = {1'b0, fmt_h};
            2: ins.op = {1'b0, fmt_w};
            3: ins.op = {1'b0, fmt_bu};
            4: ins.op = {1'b0, fmt_hu};
            5: ins.op = 4'b1000;
            6: ins.op = 4'b1001;
            default: ins.op = 4'b1010;
        endcase
        size       = ins.op[1:0];
        ins.wid    = 2'($urandom);
        ins.pc     = $urandom & 32'hffff_fffc;
        ins.tmask  = 4'($urandom);
        ins.rd     = 5'($urandom);
        ins.offset = 12'($urandom);
        off_sext   = {{20{ins.offset[11]}}, ins.offset};
        // each lane in its own small window so stores get read back
        for (int i = 0; i < num_lanes; i++) begin
            eff[i] = i * 256 + ($urandom % 32);
            eff[i] = eff[i] & ~((1 << size) - 1);
            ins.rs1_data[i] = 32'(eff[i]) - off_sext;
            ins.rs2_data[i] = $urandom;
        end
        exec       = ins;
        exec_valid = 1'b1;
        waited     = 0;
        @(posedge clk);
        while (exec_ready !== 1'b1 && !timed_out) begin
            waited++;
            if (waited > wait_limit) begin
                report_timeout("execute handshake did not complete");
            end else begin
                @(posedge clk);
            end
        end
        if (timed_out) begin
            return;
        end
        exp.wid   = ins.wid;
        exp.pc    = ins.pc;
        exp.tmask = ins.tmask;
        exp.rd    = ins.op[3] ? '0 : ins.rd;
        exp.wb    = !ins.op[3];
        exp.data  = '0;
        for (int i = 0; i < num_lanes; i++) begin
            if (ins.tmask[i] && ins.op[3]) begin
                for (int b = 0; b < (1 << size); b++) begin
                    shadow[eff[i] + b] = ins.rs2_data[i][8*b +: 8];
                end
            end else if (ins.tmask[i]) begin
                exp.data[i] = ref_load(eff[i], ins.op[2:0]);
            end
        end
        if (ins.op[3]) begin
            store_q.push_back(exp);
            stores_issued++;
        end else begin
            load_q.push_back(exp);
            loads_issued++;
        end
        #1;
        exec_valid = 1'b0;
    endtask

    initial begin
        int waited;
        void'($urandom(32'h6e857b70));
        clk           = 1'b0;
        reset         = 1'b1;
        exec_valid    = 1'b0;
        exec          = '0;
        mem_req_ready = 1'b0;
        mem_rsp_valid = 1'b0;
        mem_rsp       = '0;
        commit_ready  = 1'b0;
        for (int a = 0; a < mem_bytes; a++) begin
            mem[a]    = 8'((a * 29) ^ (a >> 5));
            shadow[a] = mem[a];
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        for (int n = 0; n < num_instrs && !timed_out; n++) begin
            issue_one();
            if ($urandom % 4 == 0) begin
                repeat (1 + $urandom % 3) @(posedge clk);
                #1;
            end
        end
        waited = 0;
        while (!timed_out && (load_q.size() > 0 || store_q.size() > 0)) begin
            waited++;
            if (waited > drain_limit) begin
                report_timeout("commits still outstanding after the last instruction");
            end else begin
                @(posedge clk);
            end
        end
        if (!timed_out) begin
            // catch stray or duplicated commits
            repeat (20) @(posedge clk);
            for (int a = 0; a < mem_bytes; a++) begin
                compare_field($sformatf("mem[%0d]", a), mem[a], shadow[a]);
            end
            compare_field("load commit count", loads_done, loads_issued);
            compare_field("store commit count", stores_done, stores_issued);
        end
        finish_run();
    end

endmodule

`default_nettype wire
